// File: src.f
src/tilesPkg.sv
src/keyCapture.sv
src/tileField.sv
src/gameReferee.sv
src/framePainter.sv
src/scoreDisplay.sv
src/pianoTiles.sv
verification/clockGen.sv
verification/pianoTilesTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module pianoTilesTb -o pianoTilesSim
./obj_dir/pianoTilesSim | tee sim.log

grep -q "STATUS: PASS" sim.log

// File: verification/pianoTilesTb.sv
`timescale 1ns/10ps
`default_nettype none

module pianoTilesTb;

	localparam int STEPS = 7;
	localparam int ACT_RESET = 0;
	localparam int ACT_FRAME = 1;
	localparam int ACT_HOLD = 2;
	localparam int ACT_HIT = 3;
	localparam int ACT_WRONG = 4;
	localparam int ACT_RESTART = 5;
	localparam int ACT_MISS = 6;
	// Active low digit patterns, segment g on bit 6
	localparam logic [6:0] SEG0 = 7'b1000000;
	localparam logic [6:0] SEG1 = 7'b1111001;

	wire CLOCK_50;
	wire rstN;
	logic [3:0] keys;
	logic creditReturn;
	tilesPkg::pixel_t pixel;
	logic pixelValid;
	logic gameOver;
	logic [6:0] hex0;
	logic [6:0] hex1;

	string testName [STEPS];
	int action [STEPS];
	int laneSel [STEPS];
	logic [13:0] expHex [STEPS];

	tilesPkg::pixelColour_e frame [160][120];
	tilesPkg::pixelColour_e snap [160][120];
	string stepName;
	int owed;
	int granted;
	int received;
	int expX;
	int expY;
	int frameCount;
	int errorCount;
	int timeoutCount;
	logic hold;
	logic sinkOn;
	logic [31:0] rng;

	clockGen clockGen_inst (
		.CLOCK_50(CLOCK_50),
		.rstN(rstN)
	);

	pianoTiles #(
		.FALL_PERIOD(8192),
		.SPAWN_PERIOD(200000)
	) pianoTiles_inst (
		.CLOCK_50(CLOCK_50),
		.rstN(rstN),
		.keys(keys),
		.creditReturn(creditReturn),
		.pixel(pixel),
		.pixelValid(pixelValid),
		.gameOver(gameOver),
		.hex0(hex0),
		.hex1(hex1)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	task automatic initTable();
		testName[0] = "reset state";
		action[0] = ACT_RESET;
		laneSel[0] = 0;
		expHex[0] = {SEG0, SEG0};
		testName[1] = "frame colours";
		action[1] = ACT_FRAME;
		laneSel[1] = 0;
		expHex[1] = {SEG0, SEG0};
		testName[2] = "credit back-pressure";
		action[2] = ACT_HOLD;
		laneSel[2] = 0;
		expHex[2] = {SEG0, SEG0};
		testName[3] = "hit";
		action[3] = ACT_HIT;
		laneSel[3] = -1;
		expHex[3] = {SEG0, SEG1};
		testName[4] = "wrong press";
		action[4] = ACT_WRONG;
		laneSel[4] = -1;
		expHex[4] = {SEG0, SEG1};
		testName[5] = "restart";
		action[5] = ACT_RESTART;
		laneSel[5] = 2;
		expHex[5] = {SEG0, SEG0};
		testName[6] = "miss";
		action[6] = ACT_MISS;
		laneSel[6] = 0;
		expHex[6] = {SEG0, SEG0};
	endtask

	// Pixel sink, frame capture and raster order
	task automatic takePixel();
		received = received + 1;
		owed = owed + 1;
		if (received > granted)
		begin
			$display("Pixel received without a granted credit");
			errorCount = errorCount + 1;
		end
		if (int'(pixel.x) != expX || int'(pixel.y) != expY)
		begin
			$display("ERR %s raster order expected (%0d,%0d) actual (%0d,%0d)",
				stepName, expX, expY, pixel.x, pixel.y);
			errorCount = errorCount + 1;
		end
		if (int'(pixel.x) < 160 && int'(pixel.y) < 120)
			frame[pixel.x][pixel.y] = pixel.colour;
		// Next position in raster order
		expX = expX + 1;
		if (expX == 160)
		begin
			expX = 0;
			expY = (expY == 119) ? 0 : expY + 1;
		end
		if (int'(pixel.x) == 159 && int'(pixel.y) == 119)
		begin
			snap = frame;
			frameCount = frameCount + 1;
		end
	endtask

	initial
	begin
		creditReturn = 1'b0;
		forever
		begin
			@(posedge CLOCK_50);
			#2;
			if (pixelValid)
				takePixel();
			if (sinkOn && !hold && owed > 0)
			begin
				creditReturn = 1'b1;
				owed = owed - 1;
				granted = granted + 1;
			end
			else
				creditReturn = 1'b0;
		end
	end

	task automatic waitFrame();
		int start;
		int n;
		start = frameCount;
		n = 0;
		while (frameCount == start && n < 100000)
		begin
			@(negedge CLOCK_50);
			n = n + 1;
		end
		if (frameCount == start)
		begin
			$display("Timed out waiting for a complete frame");
			timeoutCount = timeoutCount + 1;
		end
	endtask

	task automatic waitGameOver(input logic level, input int limit);
		int n;
		n = 0;
		while (gameOver !== level && n < limit)
		begin
			@(negedge CLOCK_50);
			n = n + 1;
		end
		if (gameOver !== level)
		begin
			$display("Timed out waiting for gameOver to become %0b", level);
			timeoutCount = timeoutCount + 1;
		end
	endtask

	task automatic pressLane(input int lane);
		@(posedge CLOCK_50);
		#2;
		keys[3 - lane] = 1'b0;
		repeat (4) @(posedge CLOCK_50);
		#2;
		keys = 4'hF;
	endtask

	task automatic checkHex(input string name, input logic [13:0] exp);
		if ({hex1, hex0} !== exp)
		begin
			$display("ERR %s expected %b actual %b", name, exp, {hex1, hex0});
			errorCount = errorCount + 1;
		end
	endtask

	// Middle column of a lane in the last frame
	function automatic int laneColumn(input int lane);
		return 4 + lane * 39 + 17;
	endfunction

	// Lowest BLACK row above the boundary row, or -1
	function automatic int blackBottom(input int lane);
		for (int y = 118; y >= 0; y--)
		begin
			if (snap[laneColumn(lane)][y] == tilesPkg::BLACK)
				return y;
		end
		return -1;
	endfunction

	function automatic bit laneHas(input int lane, input bit blueOnly);
		tilesPkg::pixelColour_e c;
		for (int y = 60; y <= 118; y++)
		begin
			c = snap[laneColumn(lane)][y];
			if (c == tilesPkg::BLUE || (!blueOnly && c == tilesPkg::BLACK))
				return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic checkFrame(input string name);
		int bad;
		tilesPkg::pixelColour_e want;
		bit border;
		bad = 0;
		for (int x = 0; x < 160; x++)
		begin
			border = ((x % 39) < 4);
			for (int y = 0; y < 120; y++)
			begin
				want = (y == 119) ? tilesPkg::RED : tilesPkg::GREEN;
				if ((y == 119 || border) && snap[x][y] != want)
				begin
					if (bad == 0)
						$display("ERR %s expected %b actual %b at (%0d,%0d)",
							name, want, snap[x][y], x, y);
					bad = bad + 1;
				end
				else if (y != 119 && !border && snap[x][y] != tilesPkg::WHITE
					&& snap[x][y] != tilesPkg::BLACK && snap[x][y] != tilesPkg::BLUE)
				begin
					if (bad == 0)
						$display("Pixel (%0d,%0d) has an illegal colour", x, y);
					bad = bad + 1;
				end
			end
		end
		errorCount = errorCount + bad;
	endtask

	task automatic runStep(input int i);
		int lane;
		int tries;
		int n;
		int startRecv;
		int startOut;
		lane = laneSel[i];
		stepName = testName[i];
		case (action[i])
			ACT_RESET:
			begin
				repeat (5)
				begin
					@(negedge CLOCK_50);
					if (pixelValid !== 1'b0)
					begin
						$display("ERR %s expected 0 actual %b", testName[i], pixelValid);
						errorCount = errorCount + 1;
					end
				end
				if (gameOver !== 1'b0)
				begin
					$display("ERR %s expected 0 actual %b", testName[i], gameOver);
					errorCount = errorCount + 1;
				end
				owed = 4;
				sinkOn = 1'b1;
			end
			ACT_FRAME:
			begin
				waitFrame();
				checkFrame(testName[i]);
			end
			ACT_HOLD:
			begin
				rng = xorshift(rng);
				n = 10 + int'(rng % 32'd41);
				hold = 1'b1;
				startRecv = received;
				startOut = granted - received;
				repeat (n) @(negedge CLOCK_50);
				if (received - startRecv > startOut || pixelValid !== 1'b0)
				begin
					$display("Pixels kept arriving while credit was withheld");
					errorCount = errorCount + 1;
				end
				hold = 1'b0;
				startRecv = received;
				tries = 0;
				while (received == startRecv && tries < 20)
				begin
					@(negedge CLOCK_50);
					tries = tries + 1;
				end
				if (received == startRecv)
				begin
					$display("No pixel arrived after credit resumed");
					timeoutCount = timeoutCount + 1;
				end
			end
			ACT_HIT:
			begin
				tries = 0;
				while (lane < 0 && tries < 100)
				begin
					waitFrame();
					for (int l = 0; l < 4; l++)
					begin
						if (lane < 0 && blackBottom(l) >= 90 && blackBottom(l) <= 105)
							lane = l;
					end
					tries = tries + 1;
				end
				if (lane < 0)
				begin
					$display("No tile reached the hit zone in time");
					timeoutCount = timeoutCount + 1;
				end
				else
				begin
					pressLane(lane);
					n = 0;
					while ({hex1, hex0} !== expHex[i] && n < 20)
					begin
						@(negedge CLOCK_50);
						n = n + 1;
					end
					if ({hex1, hex0} !== expHex[i])
					begin
						$display("Timed out waiting for the score to change");
						timeoutCount = timeoutCount + 1;
					end
					waitFrame();
					waitFrame();
					if (!laneHas(lane, 1'b1))
					begin
						$display("Hit tile in lane %0d is not shown as scored", lane);
						errorCount = errorCount + 1;
					end
				end
			end
			ACT_WRONG:
			begin
				for (int l = 3; l >= 0; l--)
				begin
					if (!laneHas(l, 1'b0))
						lane = l;
				end
				if (lane < 0 || gameOver !== 1'b0)
				begin
					$display("No empty lane while playing for the wrong press");
					errorCount = errorCount + 1;
				end
				else
				begin
					pressLane(lane);
					waitGameOver(1'b1, 20);
				end
			end
			ACT_RESTART:
			begin
				pressLane(lane);
				waitGameOver(1'b0, 20);
			end
			default:
				waitGameOver(1'b1, 3000000);
		endcase
		checkHex(testName[i], expHex[i]);
	endtask

	initial
	begin
		keys = 4'hF;
		hold = 1'b0;
		sinkOn = 1'b0;
		owed = 0;
		granted = 0;
		received = 0;
		expX = 0;
		expY = 0;
		frameCount = 0;
		errorCount = 0;
		timeoutCount = 0;
		rng = 32'd91028;
		stepName = "";
		initTable();
		@(posedge rstN);
		for (int i = 0; i < STEPS; i++)
			runStep(i);
		$display("errors %0d timeouts %0d", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen (
	output logic CLOCK_50,
	output logic rstN
);

	// 20 ns period
	initial
	begin
		CLOCK_50 = 1'b0;
		forever
			#10 CLOCK_50 = ~CLOCK_50;
	end

	// Reset low for two rising edges, released just after the second
	initial
	begin
		rstN = 1'b0;
		repeat (2) @(posedge CLOCK_50);
		#2;
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

// File: src/pianoTiles.sv
`timescale 1ns/10ps
`default_nettype none

module pianoTiles #(
	parameter int unsigned FALL_PERIOD = 416666,
	parameter int unsigned SPAWN_PERIOD = 50000000
) (
	input wire CLOCK_50,
	input wire rstN,
	input wire [3:0] keys,
	input wire creditReturn,
	output tilesPkg::pixel_t pixel,
	output logic pixelValid,
	output logic gameOver,
	output logic [6:0] hex0,
	output logic [6:0] hex1
);

	tilesPkg::lanePress_t presses;
	tilesPkg::tileSet_t tiles;
	tilesPkg::score_t score;
	logic [tilesPkg::TILE_SLOTS-1:0] hitSlots;
	logic missed;
	logic restart;
	logic playing;

	keyCapture keyCapture_inst (
		.CLOCK_50(CLOCK_50),
		.rstN(rstN),
		.keys(keys),
		.presses(presses)
	);

	tileField #(
		.FALL_PERIOD(FALL_PERIOD),
		.SPAWN_PERIOD(SPAWN_PERIOD)
	) tileField_inst (
		.CLOCK_50(CLOCK_50),
		.rstN(rstN),
		.playing(playing),
		.restart(restart),
		.hitSlots(hitSlots),
		.tiles(tiles),
		.missed(missed)
	);

	// Judges presses against the tiles and owns the score
	gameReferee gameReferee_inst (
		.CLOCK_50(CLOCK_50),
		.rstN(rstN),
		.presses(presses),
		.tiles(tiles),
		.missed(missed),
		.hitSlots(hitSlots),
		.restart(restart),
		.playing(playing),
		.score(score),
		.gameOver(gameOver)
	);

	framePainter framePainter_inst (
		.CLOCK_50(CLOCK_50),
		.rstN(rstN),
		.tiles(tiles),
		.creditReturn(creditReturn),
		.pixel(pixel),
		.pixelValid(pixelValid)
	);

	scoreDisplay scoreDisplay_inst (
		.score(score),
		.hex0(hex0),
		.hex1(hex1)
	);

endmodule

`default_nettype wire

// File: src/scoreDisplay.sv
`timescale 1ns/10ps
`default_nettype none

module scoreDisplay (
	input wire tilesPkg::score_t score,
	output logic [6:0] hex0,
	output logic [6:0] hex1
);

	localparam logic [6:0] BLANK = 7'b1111111;

	logic [3:0] tens;
	logic [3:0] ones;

	// Active low, segment g on bit 6
	function automatic logic [6:0] segments(input logic [3:0] digit);
		case (digit)
			4'd0: segments = 7'b1000000;
			4'd1: segments = 7'b1111001;
			4'd2: segments = 7'b0100100;
			4'd3: segments = 7'b0110000;
			4'd4: segments = 7'b0011001;
			4'd5: segments = 7'b0010010;
			4'd6: segments = 7'b0000010;
			4'd7: segments = 7'b1111000;
			4'd8: segments = 7'b0000000;
			4'd9: segments = 7'b0010000;
			default: segments = BLANK;
		endcase
	endfunction

	// Tens only fits a digit below 100
	assign tens = 4'(score / 8'd10);
	assign ones = 4'(score % 8'd10);

	assign hex0 = segments(ones);
	assign hex1 = (score >= 8'd100) ? BLANK : segments(tens);

endmodule

`default_nettype wire

// File: src/framePainter.sv
`timescale 1ns/10ps
`default_nettype none

module framePainter (
	input wire CLOCK_50,
	input wire rstN,
	input wire tilesPkg::tileSet_t tiles,
	input wire creditReturn,
	output tilesPkg::pixel_t pixel,
	output logic pixelValid
);

	localparam int CREDIT_BITS = 8;

	logic [CREDIT_BITS-1:0] credits;
	logic canSend;
	tilesPkg::xCoord_t scanX;
	tilesPkg::yCoord_t scanY;
	tilesPkg::pixelColour_e colour;
	tilesPkg::xCoord_t laneLeft;
	logic [7:0] tileBottom;
	logic onBorder;
	logic onTile;
	logic tileScored;

	// A credit arriving this cycle can be spent at once
	assign canSend = (credits != '0) || creditReturn;

	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			credits <= '0;
			scanX <= '0;
			scanY <= '0;
		end
		else
		begin
			credits <= credits + CREDIT_BITS'(creditReturn) - CREDIT_BITS'(canSend);
			if (canSend)
			begin
				if (scanX == tilesPkg::xCoord_t'(tilesPkg::SCREEN_WIDTH - 1))
				begin
					scanX <= '0;
					if (scanY == tilesPkg::yCoord_t'(tilesPkg::SCREEN_HEIGHT - 1))
						scanY <= '0;
					else
						scanY <= scanY + 1'b1;
				end
				else
					scanX <= scanX + 1'b1;
			end
		end
	end

	always_comb
	begin
		onBorder = 1'b0;
		for (int k = 0; k <= tilesPkg::LANE_COUNT; k++)
		begin
			if (scanX >= tilesPkg::xCoord_t'(k * tilesPkg::LANE_PITCH)
				&& scanX < tilesPkg::xCoord_t'(k * tilesPkg::LANE_PITCH + tilesPkg::BORDER_WIDTH))
				onBorder = 1'b1;
		end
		onTile = 1'b0;
		tileScored = 1'b0;
		for (int s = 0; s < tilesPkg::TILE_SLOTS; s++)
		begin
			laneLeft = tilesPkg::xCoord_t'(tilesPkg::BORDER_WIDTH)
				+ tilesPkg::xCoord_t'(tiles.slot[s].lane) * tilesPkg::xCoord_t'(tilesPkg::LANE_PITCH);
			tileBottom = {1'b0, tiles.slot[s].yTop} + 8'(tilesPkg::TILE_HEIGHT - 1);
			if (!onTile && tiles.slot[s].active
				&& scanX >= laneLeft && scanX < laneLeft + tilesPkg::xCoord_t'(tilesPkg::LANE_WIDTH)
				&& scanY >= tiles.slot[s].yTop && {1'b0, scanY} <= tileBottom)
			begin
				onTile = 1'b1;
				tileScored = tiles.slot[s].scored;
			end
		end
		// Boundary row over borders over tiles
		if (scanY == tilesPkg::yCoord_t'(tilesPkg::SCREEN_HEIGHT - 1))
			colour = tilesPkg::RED;
		else if (onBorder)
			colour = tilesPkg::GREEN;
		else if (onTile)
			colour = tileScored ? tilesPkg::BLUE : tilesPkg::BLACK;
		else
			colour = tilesPkg::WHITE;
	end

	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
			pixelValid <= 1'b0;
		else
			pixelValid <= canSend;
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (canSend)
			pixel <= '{x: scanX, y: scanY, colour: colour};
	end

endmodule

`default_nettype wire

// File: src/gameReferee.sv
`timescale 1ns/10ps
`default_nettype none

module gameReferee (
	input wire CLOCK_50,
	input wire rstN,
	input wire tilesPkg::lanePress_t presses,
	input wire tilesPkg::tileSet_t tiles,
	input wire missed,
	output logic [tilesPkg::TILE_SLOTS-1:0] hitSlots,
	output logic restart,
	output logic playing,
	output tilesPkg::score_t score,
	output logic gameOver
);

	localparam int COUNT_BITS = $clog2(tilesPkg::TILE_SLOTS + 1);

	tilesPkg::gameState_e state;
	logic [tilesPkg::TILE_SLOTS-1:0] hittable;
	logic [tilesPkg::TILE_SLOTS-1:0] hitMask;
	logic [COUNT_BITS-1:0] hitCount;
	logic [7:0] bottomRow;
	logic laneFound;
	logic laneScored;
	logic fault;

	// Bottom row inside the last TILE_HEIGHT rows
	always_comb
	begin
		for (int s = 0; s < tilesPkg::TILE_SLOTS; s++)
		begin
			bottomRow = {1'b0, tiles.slot[s].yTop} + 8'(tilesPkg::TILE_HEIGHT - 1);
			hittable[s] = tiles.slot[s].active
				&& (bottomRow >= 8'(tilesPkg::SCREEN_HEIGHT - tilesPkg::TILE_HEIGHT))
				&& (bottomRow < 8'(tilesPkg::SCREEN_HEIGHT));
		end
	end

	// Per pressed lane, hit the first unscored tile or flag a fault
	always_comb
	begin
		hitMask = '0;
		fault = 1'b0;
		for (int l = 0; l < tilesPkg::LANE_COUNT; l++)
		begin
			laneFound = 1'b0;
			laneScored = 1'b0;
			for (int s = 0; s < tilesPkg::TILE_SLOTS; s++)
			begin
				if (presses[l] && hittable[s] && tiles.slot[s].lane == tilesPkg::lane_t'(l))
				begin
					if (tiles.slot[s].scored)
						laneScored = 1'b1;
					else if (!laneFound)
					begin
						laneFound = 1'b1;
						hitMask[s] = 1'b1;
					end
				end
			end
			// A repeat on an already scored tile is harmless
			if (presses[l] && !laneFound && !laneScored)
				fault = 1'b1;
		end
		hitCount = '0;
		for (int s = 0; s < tilesPkg::TILE_SLOTS; s++)
			hitCount = hitCount + COUNT_BITS'(hitMask[s]);
	end

	assign playing = (state == tilesPkg::PLAYING);
	assign gameOver = (state == tilesPkg::OVER);
	assign restart = gameOver && (|presses);
	assign hitSlots = playing ? hitMask : '0;

	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= tilesPkg::PLAYING;
			score <= '0;
		end
		else
		begin
			case (state)
				tilesPkg::PLAYING:
				begin
					score <= score + tilesPkg::score_t'(hitCount);
					if (fault || missed)
						state <= tilesPkg::OVER;
				end
				tilesPkg::OVER:
				begin
					// Any key starts a new game
					if (restart)
					begin
						state <= tilesPkg::PLAYING;
						score <= '0;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/tileField.sv
`timescale 1ns/10ps
`default_nettype none

module tileField #(
	parameter int unsigned FALL_PERIOD = 416666,
	parameter int unsigned SPAWN_PERIOD = 50000000
) (
	input wire CLOCK_50,
	input wire rstN,
	input wire playing,
	input wire restart,
	input wire [tilesPkg::TILE_SLOTS-1:0] hitSlots,
	output tilesPkg::tileSet_t tiles,
	output logic missed
);

	localparam int FALL_BITS = $clog2(FALL_PERIOD + 1);
	localparam int SPAWN_BITS = $clog2(SPAWN_PERIOD + 1);
	localparam int SLOT_BITS = $clog2(tilesPkg::TILE_SLOTS);
	localparam logic [23:0] LFSR_SEED = 24'h800001;

	logic [23:0] lfsr;
	logic [FALL_BITS-1:0] fallCount;
	logic [SPAWN_BITS-1:0] spawnCount;
	logic fallTick;
	logic spawnTick;
	logic [SLOT_BITS-1:0] freeSlot;
	logic freeFound;
	tilesPkg::tileSet_t tilesNext;
	logic missedNext;

	// Free running, lane choice comes from the low bits
	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
			lfsr <= LFSR_SEED;
		else
			lfsr <= {lfsr[22:0], lfsr[23] ^ lfsr[22] ^ lfsr[17] ^ lfsr[16]};
	end

	assign fallTick = playing && (fallCount == FALL_BITS'(FALL_PERIOD - 1));
	assign spawnTick = playing && (spawnCount == SPAWN_BITS'(SPAWN_PERIOD - 1));

	// Both timers stand still during game over
	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			fallCount <= '0;
			spawnCount <= '0;
		end
		else if (restart)
		begin
			fallCount <= '0;
			spawnCount <= '0;
		end
		else if (playing)
		begin
			fallCount <= fallTick ? '0 : fallCount + 1'b1;
			spawnCount <= spawnTick ? '0 : spawnCount + 1'b1;
		end
	end

	// Lowest-index empty slot
	always_comb
	begin
		freeFound = 1'b0;
		freeSlot = '0;
		for (int s = 0; s < tilesPkg::TILE_SLOTS; s++)
		begin
			if (!tiles.slot[s].active && !freeFound)
			begin
				freeFound = 1'b1;
				freeSlot = SLOT_BITS'(s);
			end
		end
	end

	always_comb
	begin
		tilesNext = tiles;
		missedNext = 1'b0;
		for (int s = 0; s < tilesPkg::TILE_SLOTS; s++)
		begin
			if (hitSlots[s])
				tilesNext.slot[s].scored = 1'b1;
			if (fallTick && tiles.slot[s].active)
			begin
				tilesNext.slot[s].yTop = tiles.slot[s].yTop + 1'b1;
				// Top row moves past the last screen row
				if (tiles.slot[s].yTop == tilesPkg::yCoord_t'(tilesPkg::SCREEN_HEIGHT - 1))
				begin
					tilesNext.slot[s].active = 1'b0;
					if (!tiles.slot[s].scored)
						missedNext = 1'b1;
				end
			end
		end
		// No free slot means this spawn is skipped
		if (spawnTick && freeFound)
			tilesNext.slot[freeSlot] = '{active: 1'b1, scored: 1'b0, lane: lfsr[1:0], yTop: '0};
	end

	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			tiles <= '0;
			missed <= 1'b0;
		end
		else if (restart)
		begin
			tiles <= '0;
			missed <= 1'b0;
		end
		else
		begin
			tiles <= tilesNext;
			missed <= missedNext;
		end
	end

endmodule

`default_nettype wire

// File: src/keyCapture.sv
`timescale 1ns/10ps
`default_nettype none

module keyCapture (
	input wire CLOCK_50,
	input wire rstN,
	input wire [3:0] keys,
	output tilesPkg::lanePress_t presses
);

	// Keys in lane order, KEY[3] is lane 0
	tilesPkg::lanePress_t laneKeys;
	tilesPkg::lanePress_t syncMeta;
	tilesPkg::lanePress_t syncKeys;
	tilesPkg::lanePress_t lastKeys;

	always_comb
	begin
		for (int k = 0; k < tilesPkg::LANE_COUNT; k++)
		begin
			laneKeys[tilesPkg::LANE_COUNT - 1 - k] = keys[k];
		end
	end

	// Two-flop synchronizer, then edge register
	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			// Keys idle high
			syncMeta <= '1;
			syncKeys <= '1;
			lastKeys <= '1;
			presses <= '0;
		end
		else
		begin
			syncMeta <= laneKeys;
			syncKeys <= syncMeta;
			lastKeys <= syncKeys;
			// High to low on a synchronized key
			presses <= lastKeys & ~syncKeys;
		end
	end

endmodule

`default_nettype wire

// File: src/tilesPkg.sv
`default_nettype none

package tilesPkg;

	// Screen size in pixels
	localparam int SCREEN_WIDTH = 160;
	localparam int SCREEN_HEIGHT = 120;

	// Lane layout, each lane sits to the right of a border
	localparam int LANE_COUNT = 4;
	localparam int LANE_WIDTH = 35;
	localparam int BORDER_WIDTH = 4;
	localparam int LANE_PITCH = LANE_WIDTH + BORDER_WIDTH;

	// Tile size, also the depth of the hit zone
	localparam int TILE_HEIGHT = 30;
	localparam int TILE_SLOTS = 4;

	typedef logic [7:0] xCoord_t;
	typedef logic [6:0] yCoord_t;
	typedef logic [1:0] lane_t;
	typedef logic [7:0] score_t;

	// 3-bit RGB
	typedef enum logic [2:0] {
		// Tile
		BLACK = 3'b000,
		// Tile already scored
		BLUE = 3'b001,
		// Lane borders
		GREEN = 3'b010,
		// Bottom boundary row
		RED = 3'b100,
		// Empty lane
		WHITE = 3'b111
	} pixelColour_e;

	typedef enum logic {
		PLAYING,
		OVER
	} gameState_e;

	typedef struct packed {
		logic active;
		logic scored;
		lane_t lane;
		// Top row of the tile
		yCoord_t yTop;
	} tileSlot_t;

	typedef struct packed {
		tileSlot_t [TILE_SLOTS-1:0] slot;
	} tileSet_t;

	// One bit per lane
	typedef logic [LANE_COUNT-1:0] lanePress_t;

	typedef struct packed {
		xCoord_t x;
		yCoord_t y;
		pixelColour_e colour;
	} pixel_t;

endpackage

`default_nettype wire
